//--- design/spi_flash_pkg.sv
package spi_flash_pkg;

	//////////////////////////////////////////////////
	// Bus and flash widths
	//////////////////////////////////////////////////

	localparam int FLASH_ADDR_W = 24;
	localparam int WORD_W = 32;
	localparam int STRB_W = WORD_W / 8;
	localparam int RESP_W = 2;
	localparam int OPCODE_W = 8;

	typedef logic [FLASH_ADDR_W-1:0] flash_addr_t;
	typedef logic [WORD_W-1:0] flash_word_t;
	typedef logic [RESP_W-1:0] axi_resp_t;

	// Byte offset bits inside a word are cleared
	localparam flash_addr_t WORD_ALIGN_MASK = ~flash_addr_t'(STRB_W - 1);
	localparam axi_resp_t RESP_OKAY = 2'b00;

	//////////////////////////////////////////////////
	// SPI read framing
	//////////////////////////////////////////////////

	// Standard slow read command
	localparam logic [OPCODE_W-1:0] READ_OPCODE = 8'h03;
	// Opcode plus address, then data
	localparam int CMD_BITS = OPCODE_W + FLASH_ADDR_W;
	localparam int XFER_BITS = CMD_BITS + WORD_W;
	localparam int BIT_CNT_W = $clog2(XFER_BITS);

	typedef logic [BIT_CNT_W-1:0] bit_cnt_t;
	localparam bit_cnt_t LAST_BIT = bit_cnt_t'(XFER_BITS - 1);

	typedef enum logic [1:0] {IDLE, SHIFT, FINISH} seq_state_t;

	// Read start from the bus port
	typedef struct packed {
		logic start;
		flash_addr_t addr;
	} read_req_t;

	// Flash pins
	typedef struct packed {
		logic cs_n;
		logic sck;
		logic mosi;
	} spi_out_t;

endpackage

//--- design/flash_axi_port.sv
`timescale 1ns/1ps

module flash_axi_port
(
	input  logic i_clk,
	input  logic i_reset,

	// Sequencer and capture side
	input  logic i_seq_done,
	input  spi_flash_pkg::flash_word_t i_cap_word,
	output spi_flash_pkg::read_req_t o_req,

	// AXI read address channel
	input  logic i_arvalid,
	output logic o_arready,
	input  spi_flash_pkg::flash_addr_t i_araddr,

	// AXI read data channel
	output logic o_rvalid,
	input  logic i_rready,
	output spi_flash_pkg::flash_word_t o_rdata,
	output spi_flash_pkg::axi_resp_t o_rresp,

	// AXI write address and data channels
	input  logic i_awvalid,
	output logic o_awready,
	input  spi_flash_pkg::flash_addr_t i_awaddr,
	input  logic i_wvalid,
	output logic o_wready,
	input  spi_flash_pkg::flash_word_t i_wdata,
	input  logic [spi_flash_pkg::STRB_W-1:0] i_wstrb,

	// AXI write response channel
	output logic o_bvalid,
	input  logic i_bready,
	output spi_flash_pkg::axi_resp_t o_bresp
);

	logic rd_busy;
	logic ar_fire;
	logic r_fire;
	logic wr_fire;
	logic b_fire;

	//////////////////////////////////////////////////
	// Read path
	//////////////////////////////////////////////////

	// Busy from AR handshake until R handshake
	// covers both the SPI frame and the held response
	assign o_arready = !rd_busy;
	assign ar_fire = i_arvalid && o_arready;
	assign r_fire = o_rvalid && i_rready;

	// Start strobe in the handshake cycle
	always_comb
	begin
		o_req.start = ar_fire;
		o_req.addr = i_araddr & spi_flash_pkg::WORD_ALIGN_MASK;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			rd_busy <= 1'b0;
			o_rvalid <= 1'b0;
		end
		else
		begin
			if (ar_fire)
				rd_busy <= 1'b1;
			else if (r_fire)
				rd_busy <= 1'b0;

			// Response goes out the clock after the frame ends
			if (i_seq_done)
				o_rvalid <= 1'b1;
			else if (r_fire)
				o_rvalid <= 1'b0;
		end
	end

	// Captured word held until the master takes it
	always_ff @(posedge i_clk)
	begin
		if (i_seq_done)
			o_rdata <= i_cap_word;
	end

	assign o_rresp = spi_flash_pkg::RESP_OKAY;

	//////////////////////////////////////////////////
	// Write path
	//////////////////////////////////////////////////

	// Read-only flash, so i_awaddr, i_wdata and i_wstrb are dropped
	// AW and W taken together, blocked while a response is held
	assign wr_fire = i_awvalid && i_wvalid && !o_bvalid;
	assign o_awready = wr_fire;
	assign o_wready = wr_fire;
	assign b_fire = o_bvalid && i_bready;

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_bvalid <= 1'b0;
		else if (wr_fire)
			o_bvalid <= 1'b1;
		else if (b_fire)
			o_bvalid <= 1'b0;
	end

	// Always OKAY
	assign o_bresp = spi_flash_pkg::RESP_OKAY;

endmodule

//--- design/spi_read_sequencer.sv
`timescale 1ns/1ps

module spi_read_sequencer
(
	input  logic i_clk,
	input  logic i_reset,
	input  spi_flash_pkg::read_req_t i_req,
	output spi_flash_pkg::spi_out_t o_spi,
	output logic o_seq_done
);

	spi_flash_pkg::seq_state_t state;
	// Opcode and address, MSB goes out first
	logic [spi_flash_pkg::CMD_BITS-1:0] cmd_sr;
	spi_flash_pkg::bit_cnt_t bit_cnt;
	// Low for one clock, high for one clock
	logic sck_phase;
	logic last_bit;

	// High phase of the final bit in the frame
	assign last_bit = sck_phase && (bit_cnt == spi_flash_pkg::LAST_BIT);

	//////////////////////////////////////////////////
	// Frame FSM
	//////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			state <= spi_flash_pkg::IDLE;
			sck_phase <= 1'b0;
			bit_cnt <= '0;
			// Keeps MOSI low out of reset
			cmd_sr <= '0;
		end
		else
		begin
			case (state)
				spi_flash_pkg::IDLE:
				begin
					if (i_req.start)
					begin
						state <= spi_flash_pkg::SHIFT;
						cmd_sr <= {spi_flash_pkg::READ_OPCODE, i_req.addr};
						bit_cnt <= '0;
						sck_phase <= 1'b0;
					end
				end

				spi_flash_pkg::SHIFT:
				begin
					sck_phase <= !sck_phase;
					// Next bit moves up at the end of each high phase
					// zero fill covers the data phase
					if (sck_phase)
					begin
						cmd_sr <= {cmd_sr[spi_flash_pkg::CMD_BITS-2:0], 1'b0};
						bit_cnt <= bit_cnt + spi_flash_pkg::bit_cnt_t'(1);
						if (last_bit)
							state <= spi_flash_pkg::FINISH;
					end
				end

				// One clock with CS released, done strobe out
				spi_flash_pkg::FINISH:
					state <= spi_flash_pkg::IDLE;

				default:
					state <= spi_flash_pkg::IDLE;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Pins and done strobe
	//////////////////////////////////////////////////

	// Chip select only asserted while bits are moving
	always_comb
	begin
		o_spi.cs_n = (state != spi_flash_pkg::SHIFT);
		o_spi.sck = sck_phase;
		o_spi.mosi = cmd_sr[spi_flash_pkg::CMD_BITS-1];
	end

	// Clock after the last SCK rising edge
	assign o_seq_done = (state == spi_flash_pkg::FINISH);

endmodule

//--- design/spi_data_capture.sv
`timescale 1ns/1ps

module spi_data_capture
(
	input  logic i_clk,
	input  spi_flash_pkg::spi_out_t i_spi,
	input  logic i_spi_miso,
	output spi_flash_pkg::flash_word_t o_cap_word
);

	logic sample_en;

	//////////////////////////////////////////////////
	// MISO sampling
	//////////////////////////////////////////////////

	// High SCK phase inside an active frame
	// flash sees its rising edge at the start of this clock
	assign sample_en = !i_spi.cs_n && i_spi.sck;

	// Shift in MSB first on every sampled bit
	// Command phase bits fall off the top, so after 64 bits
	// only the 32 data bits remain
	always_ff @(posedge i_clk)
	begin
		if (sample_en)
			o_cap_word <= {o_cap_word[spi_flash_pkg::WORD_W-2:0], i_spi_miso};
	end

	// Last sample lands at the end of the final high phase,
	// so the word is complete in the done strobe cycle

endmodule

//--- design/spi_flash_reader.sv
`timescale 1ns/1ps

module spi_flash_reader
(
	input  logic i_clk,
	input  logic i_reset,

	// AXI4-Lite slave
	input  logic i_arvalid,
	output logic o_arready,
	input  spi_flash_pkg::flash_addr_t i_araddr,
	output logic o_rvalid,
	input  logic i_rready,
	output spi_flash_pkg::flash_word_t o_rdata,
	output spi_flash_pkg::axi_resp_t o_rresp,
	input  logic i_awvalid,
	output logic o_awready,
	input  spi_flash_pkg::flash_addr_t i_awaddr,
	input  logic i_wvalid,
	output logic o_wready,
	input  spi_flash_pkg::flash_word_t i_wdata,
	input  logic [spi_flash_pkg::STRB_W-1:0] i_wstrb,
	output logic o_bvalid,
	input  logic i_bready,
	output spi_flash_pkg::axi_resp_t o_bresp,

	// SPI flash pins
	output logic o_spi_cs_n,
	output logic o_spi_sck,
	output logic o_spi_mosi,
	input  logic i_spi_miso
);

	spi_flash_pkg::read_req_t read_req;
	spi_flash_pkg::spi_out_t spi;
	spi_flash_pkg::flash_word_t cap_word;
	logic seq_done;

	//////////////////////////////////////////////////
	// Bus port
	//////////////////////////////////////////////////

	flash_axi_port u_axi_port
	(
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_seq_done(seq_done),
		.i_cap_word(cap_word),
		.o_req(read_req),
		.i_arvalid(i_arvalid),
		.o_arready(o_arready),
		.i_araddr(i_araddr),
		.o_rvalid(o_rvalid),
		.i_rready(i_rready),
		.o_rdata(o_rdata),
		.o_rresp(o_rresp),
		.i_awvalid(i_awvalid),
		.o_awready(o_awready),
		.i_awaddr(i_awaddr),
		.i_wvalid(i_wvalid),
		.o_wready(o_wready),
		.i_wdata(i_wdata),
		.i_wstrb(i_wstrb),
		.o_bvalid(o_bvalid),
		.i_bready(i_bready),
		.o_bresp(o_bresp)
	);

	//////////////////////////////////////////////////
	// SPI side
	//////////////////////////////////////////////////

	spi_read_sequencer u_sequencer
	(
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_req(read_req),
		.o_spi(spi),
		.o_seq_done(seq_done)
	);

	// Watches the same pins the flash sees
	spi_data_capture u_capture
	(
		.i_clk(i_clk),
		.i_spi(spi),
		.i_spi_miso(i_spi_miso),
		.o_cap_word(cap_word)
	);

	// Pin struct out to the package pins
	assign o_spi_cs_n = spi.cs_n;
	assign o_spi_sck = spi.sck;
	assign o_spi_mosi = spi.mosi;

endmodule

//--- tests/spi_flash_reader_assert.sv
`timescale 1ns/1ps

module spi_flash_reader_assert
(
	input logic i_clk,
	input logic i_reset,
	input logic i_cs_n,
	input logic i_sck,
	input logic i_seq_done,
	input logic i_rvalid,
	input logic i_rready,
	input spi_flash_pkg::flash_word_t i_rdata,
	input logic i_bvalid,
	input logic i_bready
);

	//////////////////////////////////////////////////
	// SPI framing
	//////////////////////////////////////////////////

	// SCK parked low outside a frame
	a_sck_idle: assert property (@(posedge i_clk) disable iff (i_reset) i_cs_n |-> !i_sck)
		else $error("SCK high while chip select is released");

	// Done only right after an active frame
	a_done_frame: assert property (@(posedge i_clk) disable iff (i_reset)
		i_seq_done |-> $past(!i_cs_n))
		else $error("Done strobe without a preceding frame");

	//////////////////////////////////////////////////
	// AXI hold rules
	//////////////////////////////////////////////////

	a_r_hold: assert property (@(posedge i_clk) disable iff (i_reset)
		i_rvalid && !i_rready |=> i_rvalid && $stable(i_rdata))
		else $error("Read data dropped or changed before acceptance");

	a_b_hold: assert property (@(posedge i_clk) disable iff (i_reset)
		i_bvalid && !i_bready |=> i_bvalid)
		else $error("Write response dropped before acceptance");

endmodule

bind spi_flash_reader spi_flash_reader_assert u_protocol_assert
(
	.i_clk(i_clk),
	.i_reset(i_reset),
	.i_cs_n(o_spi_cs_n),
	.i_sck(o_spi_sck),
	.i_seq_done(seq_done),
	.i_rvalid(o_rvalid),
	.i_rready(i_rready),
	.i_rdata(o_rdata),
	.i_bvalid(o_bvalid),
	.i_bready(i_bready)
);

//--- tests/tb_spi_flash_reader.sv
`timescale 1ns/1ps

module tb_spi_flash_reader;

	localparam logic [31:0] SEED = 32'd49;
	localparam int NUM_TXNS = 40;
	localparam int TIMEOUT = 400;
	localparam int MEM_WORDS = 256;
	localparam int RESET_CYCLES = 3;
	// Two clocks per SPI bit, then the done clock and the response register
	localparam int READ_LATENCY = 2 * spi_flash_pkg::XFER_BITS + 2;
	// Standard flash read command
	localparam logic [7:0] READ_CMD = 8'h03;
	// AXI OKAY response code
	localparam logic [1:0] OKAY = 2'b00;

	logic i_clk;
	logic i_reset;
	logic i_arvalid;
	logic o_arready;
	spi_flash_pkg::flash_addr_t i_araddr;
	logic o_rvalid;
	logic i_rready;
	spi_flash_pkg::flash_word_t o_rdata;
	spi_flash_pkg::axi_resp_t o_rresp;
	logic i_awvalid;
	logic o_awready;
	spi_flash_pkg::flash_addr_t i_awaddr;
	logic i_wvalid;
	logic o_wready;
	spi_flash_pkg::flash_word_t i_wdata;
	logic [spi_flash_pkg::STRB_W-1:0] i_wstrb;
	logic o_bvalid;
	logic i_bready;
	spi_flash_pkg::axi_resp_t o_bresp;
	logic o_spi_cs_n;
	logic o_spi_sck;
	logic o_spi_mosi;
	logic i_spi_miso;

	logic [31:0] rng;

	// Flash contents, also the reference for every read
	logic [31:0] mem [0:MEM_WORDS-1];
	spi_flash_pkg::flash_addr_t exp_addr;
	// Flash model shift state
	logic [31:0] flash_cmd;
	logic [31:0] flash_data;
	int flash_bits;

	spi_flash_reader UUT
	(
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_arvalid(i_arvalid),
		.o_arready(o_arready),
		.i_araddr(i_araddr),
		.o_rvalid(o_rvalid),
		.i_rready(i_rready),
		.o_rdata(o_rdata),
		.o_rresp(o_rresp),
		.i_awvalid(i_awvalid),
		.o_awready(o_awready),
		.i_awaddr(i_awaddr),
		.i_wvalid(i_wvalid),
		.o_wready(o_wready),
		.i_wdata(i_wdata),
		.i_wstrb(i_wstrb),
		.o_bvalid(o_bvalid),
		.i_bready(i_bready),
		.o_bresp(o_bresp),
		.o_spi_cs_n(o_spi_cs_n),
		.o_spi_sck(o_spi_sck),
		.o_spi_mosi(o_spi_mosi),
		.i_spi_miso(i_spi_miso)
	);

	// 20 ns period
	initial
	begin
		i_clk = 1'b0;
		forever #10 i_clk = ~i_clk;
	end

	//////////////////////////////////////////////////
	// Random numbers and checks
	//////////////////////////////////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic fail_run();
		$display("TEST RESULT: FAIL");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp)
		else
		begin
			$display("[ERROR] %0t %s expected %0h actual %0h", $time, name, exp, act);
			fail_run();
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		assert (act === exp)
		else
		begin
			$display("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act);
			fail_run();
		end
	endtask

	//////////////////////////////////////////////////
	// Flash model
	//////////////////////////////////////////////////

	// New frame
	always @(negedge o_spi_cs_n)
	begin
		flash_bits = 0;
		flash_cmd = '0;
	end

	// MOSI taken on SCK rising edges
	always @(posedge o_spi_sck)
	begin
		if (!o_spi_cs_n)
		begin
			if (flash_bits < spi_flash_pkg::CMD_BITS)
				flash_cmd = {flash_cmd[30:0], o_spi_mosi};
			flash_bits = flash_bits + 1;
			if (flash_bits == spi_flash_pkg::CMD_BITS)
			begin
				check_word("o_spi_mosi opcode", {24'b0, READ_CMD},
					{24'b0, flash_cmd[31:24]});
				check_word("o_spi_mosi address", {8'b0, exp_addr}, {8'b0, flash_cmd[23:0]});
				flash_data = mem[flash_cmd[9:2]];
			end
		end
	end

	// Data bit set up on the falling edge before its high phase
	always @(negedge o_spi_sck)
	begin
		if (!o_spi_cs_n && flash_bits >= spi_flash_pkg::CMD_BITS
			&& flash_bits < spi_flash_pkg::XFER_BITS)
		begin
			i_spi_miso <= flash_data[31];
			flash_data = flash_data << 1;
		end
	end

	//////////////////////////////////////////////////
	// Bus transactions
	//////////////////////////////////////////////////

	task automatic do_read(input spi_flash_pkg::flash_addr_t addr);
		int cycles;
		int hold;
		logic [31:0] exp_word;
		// Byte offset dropped, low eight word index bits pick the entry
		exp_addr = {addr[23:2], 2'b00};
		exp_word = mem[addr[9:2]];
		i_arvalid <= 1'b1;
		i_araddr <= addr;
		cycles = 0;
		@(posedge i_clk);
		while (!o_arready)
		begin
			if (cycles >= TIMEOUT)
			begin
				$display("Timeout waiting for the read address handshake");
				fail_run();
			end
			@(posedge i_clk);
			cycles = cycles + 1;
		end
		i_arvalid <= 1'b0;
		// Response latency counted from the AR handshake edge
		cycles = 0;
		do
		begin
			@(posedge i_clk);
			cycles = cycles + 1;
			if (cycles > TIMEOUT)
			begin
				$display("Timeout waiting for the read response");
				fail_run();
			end
			check_bit("o_arready", 1'b0, o_arready);
		end
		while (!o_rvalid);
		check_word("read latency", READ_LATENCY, cycles);
		check_word("o_rdata", exp_word, o_rdata);
		check_word("o_rresp", {30'b0, OKAY}, {30'b0, o_rresp});
		// Back-pressure on R
		rng = xorshift(rng);
		hold = int'(rng[2:0]);
		for (int i = 0; i < hold; i++)
		begin
			@(posedge i_clk);
			check_bit("o_rvalid", 1'b1, o_rvalid);
			check_word("o_rdata", exp_word, o_rdata);
			check_bit("o_arready", 1'b0, o_arready);
		end
		i_rready <= 1'b1;
		@(posedge i_clk);
		check_bit("o_rvalid", 1'b1, o_rvalid);
		i_rready <= 1'b0;
	endtask

	task automatic do_write(input spi_flash_pkg::flash_addr_t addr);
		int cycles;
		int hold;
		rng = xorshift(rng);
		i_awvalid <= 1'b1;
		i_wvalid <= 1'b1;
		i_awaddr <= addr;
		i_wdata <= rng;
		i_wstrb <= rng[3:0];
		cycles = 0;
		@(posedge i_clk);
		while (!o_awready)
		begin
			if (cycles >= TIMEOUT)
			begin
				$display("Timeout waiting for the write handshake");
				fail_run();
			end
			@(posedge i_clk);
			cycles = cycles + 1;
		end
		check_bit("o_wready", 1'b1, o_wready);
		i_awvalid <= 1'b0;
		i_wvalid <= 1'b0;
		// Response one clock after the handshake
		@(posedge i_clk);
		check_bit("o_bvalid", 1'b1, o_bvalid);
		check_word("o_bresp", {30'b0, OKAY}, {30'b0, o_bresp});
		hold = int'(rng[6:4]);
		for (int i = 0; i < hold; i++)
		begin
			@(posedge i_clk);
			check_bit("o_bvalid", 1'b1, o_bvalid);
		end
		i_bready <= 1'b1;
		@(posedge i_clk);
		i_bready <= 1'b0;
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial
	begin
		logic [7:0] idx;
		spi_flash_pkg::flash_addr_t addr;
		i_reset = 1'b1;
		i_arvalid = 1'b0;
		i_araddr = '0;
		i_rready = 1'b0;
		i_awvalid = 1'b0;
		i_awaddr = '0;
		i_wvalid = 1'b0;
		i_wdata = '0;
		i_wstrb = '0;
		i_bready = 1'b0;
		i_spi_miso = 1'b0;
		exp_addr = '0;
		flash_cmd = '0;
		flash_data = '0;
		flash_bits = 0;
		// Flash image from the random stream
		rng = SEED;
		idx = '0;
		do
		begin
			rng = xorshift(rng);
			mem[idx] = rng;
			idx = idx + 8'd1;
		end
		while (idx != 8'd0);
		repeat (RESET_CYCLES) @(posedge i_clk);
		i_reset <= 1'b0;
		@(posedge i_clk);
		// Idle state before any traffic
		check_bit("o_spi_cs_n", 1'b1, o_spi_cs_n);
		check_bit("o_spi_sck", 1'b0, o_spi_sck);
		check_bit("o_rvalid", 1'b0, o_rvalid);
		check_bit("o_bvalid", 1'b0, o_bvalid);
		check_bit("o_arready", 1'b1, o_arready);
		for (int n = 0; n < NUM_TXNS; n++)
		begin
			rng = xorshift(rng);
			addr = rng[23:0];
			// Write first sometimes, the read after it still sees the flash image
			if (rng[31])
				do_write(addr);
			do_read(addr);
		end
		@(posedge i_clk);
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

//--- spi_flash_reader.f
design/spi_flash_pkg.sv
design/flash_axi_port.sv
design/spi_read_sequencer.sv
design/spi_data_capture.sv
design/spi_flash_reader.sv
tests/spi_flash_reader_assert.sv
tests/tb_spi_flash_reader.sv

//--- Makefile
# Verilator simulation of the SPI flash reader

VERILATOR ?= verilator
TOP ?= tb_spi_flash_reader
FILE_LIST ?= spi_flash_reader.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= TEST RESULT: PASS
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

# Result decided by the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
